// ==== src/tsc_pkg.sv ====
package tsc_pkg;

    // Data and address width
    localparam int word_size = 16;

    // General registers and the width of a register index
    localparam int reg_count = 4;
    localparam int reg_idx_w = $clog2(reg_count);

    // Opcodes live in instr[15:12]
    localparam logic [3:0] op_rtype = 4'd15;
    localparam logic [3:0] op_adi   = 4'd4;
    localparam logic [3:0] op_lwd   = 4'd7;
    localparam logic [3:0] op_swd   = 4'd8;

    // Function codes of R-type instructions, instr[5:0]
    localparam logic [5:0] fn_add = 6'd0;
    localparam logic [5:0] fn_sub = 6'd1;
    localparam logic [5:0] fn_and = 6'd2;
    localparam logic [5:0] fn_orr = 6'd3;
    localparam logic [5:0] fn_wwd = 6'd28;
    localparam logic [5:0] fn_hlt = 6'd29;

    // Encoded to match the low bits of the arithmetic function codes
    typedef enum logic [1:0] {
        alu_add = 2'd0,
        alu_sub = 2'd1,
        alu_and = 2'd2,
        alu_orr = 2'd3
    } alu_op_e;

    typedef struct packed {
        logic [word_size-1:0] pc;
        logic [word_size-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic [word_size-1:0] pc;
        logic [word_size-1:0] r_data1;
        logic [word_size-1:0] r_data2;
        logic [word_size-1:0] imm;
        logic [reg_idx_w-1:0] rd;
        alu_op_e              alu_op;
        logic                 alu_src_b;
        logic                 mem_read;
        logic                 mem_write;
        logic                 reg_write;
        logic                 is_wwd;
        logic                 is_halt;
    } id_ex_t;

    typedef struct packed {
        logic [word_size-1:0] alu_result;
        logic [word_size-1:0] store_data;
        logic [reg_idx_w-1:0] rd;
        logic                 mem_read;
        logic                 mem_write;
        logic                 reg_write;
        logic                 is_wwd;
        logic                 is_halt;
    } ex_mem_t;

endpackage

// ==== src/pipe_reg.sv ====
`timescale 1ns/100ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     hold,
    input  logic     bubble,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (reset_n) begin
            out_valid <= 1'b0;
        end else if (!hold) begin
            out_valid <= in_valid && !bubble;
        end
    end

    // A bubble still loads the payload, only the valid bit is dropped
    always_ff @(posedge clk) begin
        if (!hold) begin
            out_data <= in_data;
        end
    end

    // Stall drives hold on IF/ID and bubble on ID/EX, never both on one stage
    assert property (@(posedge clk) disable iff (reset_n) !(hold && bubble));

endmodule

// ==== src/fetch_stage.sv ====
`timescale 1ns/100ps

module fetch_stage import tsc_pkg::*; (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 stall,
    input  logic                 halt_seen,
    output logic [word_size-1:0] i_addr,
    input  logic [word_size-1:0] i_data,
    output logic                 out_valid,
    output if_id_t               out_data
);

    logic [word_size-1:0] pc;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc <= '0;
        end else if (!stall && !halt_seen) begin
            pc <= pc + 1'b1;
        end
    end

    assign i_addr = pc;

    // Nothing fetched past HLT enters the pipe
    assign out_valid      = !halt_seen;
    assign out_data.pc    = pc;
    assign out_data.instr = i_data;

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage import tsc_pkg::*; (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 in_valid,
    input  if_id_t               in_data,
    input  logic                 ex_valid,
    input  logic [reg_idx_w-1:0] ex_rd,
    input  logic                 ex_reg_write,
    input  logic                 mem_valid,
    input  logic [reg_idx_w-1:0] mem_rd,
    input  logic                 mem_reg_write,
    input  logic                 wb_en,
    input  logic [reg_idx_w-1:0] wb_rd,
    input  logic [word_size-1:0] wb_data,
    output logic                 stall,
    output logic                 halt_seen,
    output logic                 out_valid,
    output id_ex_t               out_data
);

    logic [3:0]           opcode;
    logic [5:0]           func;
    logic [reg_idx_w-1:0] rs;
    logic [reg_idx_w-1:0] rt;
    logic                 uses_rs;
    logic                 uses_rt;
    logic                 hazard_rs;
    logic                 hazard_rt;
    logic                 hlt_accept;
    logic                 halt_q;
    logic [word_size-1:0] rd_data1;
    logic [word_size-1:0] rd_data2;
    logic [word_size-1:0] regs [reg_count];
    id_ex_t               dec;

    assign opcode = in_data.instr[15:12];
    assign rs     = in_data.instr[11:10];
    assign rt     = in_data.instr[9:8];
    assign func   = in_data.instr[5:0];

    always_comb begin
        dec           = '0;
        dec.pc        = in_data.pc;
        dec.r_data1   = rd_data1;
        dec.r_data2   = rd_data2;
        dec.imm       = {{(word_size-8){in_data.instr[7]}}, in_data.instr[7:0]};
        dec.alu_op    = alu_add;
        uses_rs       = 1'b0;
        uses_rt       = 1'b0;
        case (opcode)
            op_rtype: begin
                dec.rd = in_data.instr[7:6];
                case (func)
                    fn_add, fn_sub, fn_and, fn_orr: begin
                        dec.alu_op    = alu_op_e'(func[1:0]);
                        dec.reg_write = 1'b1;
                        uses_rs       = 1'b1;
                        uses_rt       = 1'b1;
                    end
                    fn_wwd: begin
                        dec.is_wwd = 1'b1;
                        uses_rs    = 1'b1;
                    end
                    fn_hlt: dec.is_halt = 1'b1;
                    default: ;
                endcase
            end
            op_adi, op_lwd: begin
                dec.rd        = rt;
                dec.alu_src_b = 1'b1;
                dec.reg_write = 1'b1;
                dec.mem_read  = (opcode == op_lwd);
                uses_rs       = 1'b1;
            end
            op_swd: begin
                dec.alu_src_b = 1'b1;
                dec.mem_write = 1'b1;
                uses_rs       = 1'b1;
                uses_rt       = 1'b1;
            end
            default: ;
        endcase
    end

    // Write-through read ports
    assign rd_data1 = (wb_en && wb_rd == rs) ? wb_data : regs[rs];
    assign rd_data2 = (wb_en && wb_rd == rt) ? wb_data : regs[rt];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Producers still in execute or memory block the read
    assign hazard_rs = uses_rs &&
        ((ex_valid && ex_reg_write && ex_rd == rs) ||
         (mem_valid && mem_reg_write && mem_rd == rs));
    assign hazard_rt = uses_rt &&
        ((ex_valid && ex_reg_write && ex_rd == rt) ||
         (mem_valid && mem_reg_write && mem_rd == rt));

    assign stall      = in_valid && (hazard_rs || hazard_rt);
    assign hlt_accept = in_valid && dec.is_halt && !stall;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            halt_q <= 1'b0;
        end else if (hlt_accept) begin
            halt_q <= 1'b1;
        end
    end

    // Seen in the same cycle so fetch drops the next word at once
    assign halt_seen = halt_q || hlt_accept;

    assign out_valid = in_valid;
    assign out_data  = dec;

    assert property (@(posedge clk) disable iff (reset_n) wb_en |-> !$isunknown(wb_rd));

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage import tsc_pkg::*; (
    input  logic    in_valid,
    input  id_ex_t  in_data,
    output logic    out_valid,
    output ex_mem_t out_data
);

    logic [word_size-1:0] op_b;
    logic [word_size-1:0] alu_out;

    assign op_b = in_data.alu_src_b ? in_data.imm : in_data.r_data2;

    always_comb begin
        case (in_data.alu_op)
            alu_add: alu_out = in_data.r_data1 + op_b;
            alu_sub: alu_out = in_data.r_data1 - op_b;
            alu_and: alu_out = in_data.r_data1 & op_b;
            alu_orr: alu_out = in_data.r_data1 | op_b;
            default: alu_out = '0;
        endcase
    end

    assign out_valid = in_valid;

    // WWD carries the rs value to the output port unchanged
    assign out_data.alu_result = in_data.is_wwd ? in_data.r_data1 : alu_out;
    assign out_data.store_data = in_data.r_data2;
    assign out_data.rd         = in_data.rd;
    assign out_data.mem_read   = in_data.mem_read;
    assign out_data.mem_write  = in_data.mem_write;
    assign out_data.reg_write  = in_data.reg_write;
    assign out_data.is_wwd     = in_data.is_wwd;
    assign out_data.is_halt    = in_data.is_halt;

endmodule

// ==== src/memory_stage.sv ====
`timescale 1ns/100ps

module memory_stage import tsc_pkg::*; (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 in_valid,
    input  ex_mem_t              in_data,
    output logic [word_size-1:0] d_addr,
    input  logic [word_size-1:0] d_rdata,
    output logic [word_size-1:0] d_wdata,
    output logic                 d_write,
    output logic                 wb_en,
    output logic [reg_idx_w-1:0] wb_rd,
    output logic [word_size-1:0] wb_data,
    output logic [word_size-1:0] out_port,
    output logic                 out_valid,
    output logic                 halted
);

    assign d_addr  = in_data.alu_result;
    assign d_wdata = in_data.store_data;
    assign d_write = in_valid && in_data.mem_write;

    // Loads return data in the same cycle
    assign wb_en   = in_valid && in_data.reg_write;
    assign wb_rd   = in_data.rd;
    assign wb_data = in_data.mem_read ? d_rdata : in_data.alu_result;

    assign out_port  = in_data.alu_result;
    assign out_valid = in_valid && in_data.is_wwd;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            halted <= 1'b0;
        end else if (in_valid && in_data.is_halt) begin
            halted <= 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (reset_n)
        in_valid |-> !(in_data.mem_read && in_data.mem_write));

endmodule

// ==== src/tsc_core.sv ====
`timescale 1ns/100ps

module tsc_core import tsc_pkg::*; (
    input  logic                 clk,
    input  logic                 reset_n,
    output logic [word_size-1:0] i_addr,
    input  logic [word_size-1:0] i_data,
    output logic [word_size-1:0] d_addr,
    input  logic [word_size-1:0] d_rdata,
    output logic [word_size-1:0] d_wdata,
    output logic                 d_write,
    output logic [word_size-1:0] out_port,
    output logic                 out_valid,
    output logic                 halted
);

    logic                 stall;
    logic                 halt_seen;
    logic                 if_valid;
    if_id_t               if_data;
    logic                 id_valid;
    if_id_t               id_data;
    logic                 dec_valid;
    id_ex_t               dec_data;
    logic                 ex_valid;
    id_ex_t               ex_data;
    logic                 alu_valid;
    ex_mem_t              alu_data;
    logic                 mem_valid;
    ex_mem_t              mem_data;
    logic                 wb_en;
    logic [reg_idx_w-1:0] wb_rd;
    logic [word_size-1:0] wb_data;

    fetch_stage u_fetch (
        .clk       (clk),
        .reset_n   (reset_n),
        .stall     (stall),
        .halt_seen (halt_seen),
        .i_addr    (i_addr),
        .i_data    (i_data),
        .out_valid (if_valid),
        .out_data  (if_data)
    );

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk       (clk),
        .reset_n   (reset_n),
        .hold      (stall),
        .bubble    (1'b0),
        .in_valid  (if_valid),
        .in_data   (if_data),
        .out_valid (id_valid),
        .out_data  (id_data)
    );

    decode_stage u_decode (
        .clk           (clk),
        .reset_n       (reset_n),
        .in_valid      (id_valid),
        .in_data       (id_data),
        .ex_valid      (ex_valid),
        .ex_rd         (ex_data.rd),
        .ex_reg_write  (ex_data.reg_write),
        .mem_valid     (mem_valid),
        .mem_rd        (mem_data.rd),
        .mem_reg_write (mem_data.reg_write),
        .wb_en         (wb_en),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .stall         (stall),
        .halt_seen     (halt_seen),
        .out_valid     (dec_valid),
        .out_data      (dec_data)
    );

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk       (clk),
        .reset_n   (reset_n),
        .hold      (1'b0),
        .bubble    (stall),
        .in_valid  (dec_valid),
        .in_data   (dec_data),
        .out_valid (ex_valid),
        .out_data  (ex_data)
    );

    execute_stage u_execute (
        .in_valid  (ex_valid),
        .in_data   (ex_data),
        .out_valid (alu_valid),
        .out_data  (alu_data)
    );

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk       (clk),
        .reset_n   (reset_n),
        .hold      (1'b0),
        .bubble    (1'b0),
        .in_valid  (alu_valid),
        .in_data   (alu_data),
        .out_valid (mem_valid),
        .out_data  (mem_data)
    );

    memory_stage u_memory (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (mem_valid),
        .in_data   (mem_data),
        .d_addr    (d_addr),
        .d_rdata   (d_rdata),
        .d_wdata   (d_wdata),
        .d_write   (d_write),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .out_port  (out_port),
        .out_valid (out_valid),
        .halted    (halted)
    );

endmodule

// ==== dv/tsc_mem_model.sv ====
`timescale 1ns/100ps

module tsc_mem_model import tsc_pkg::*; #(
    parameter int depth = 256
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic [word_size-1:0] i_addr,
    output logic [word_size-1:0] i_data,
    input  logic [word_size-1:0] d_addr,
    output logic [word_size-1:0] d_rdata,
    input  logic [word_size-1:0] d_wdata,
    input  logic                 d_write
);

    localparam int aw = $clog2(depth);

    // Filled by the testbench before the first clock edge
    logic [word_size-1:0] rom      [depth];
    logic [word_size-1:0] ram_init [depth];
    logic [word_size-1:0] ram      [depth];

    assign i_data  = rom[i_addr[aw-1:0]];
    assign d_rdata = ram[d_addr[aw-1:0]];

    // Reset reloads the data RAM from its start image
    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < depth; i++) begin
                ram[i] <= ram_init[i];
            end
        end else if (d_write) begin
            ram[d_addr[aw-1:0]] <= d_wdata;
        end
    end

endmodule

// ==== dv/tsc_core_tb.sv ====
`timescale 1ns/100ps

module tsc_core_tb import tsc_pkg::*; ();

    localparam int clk_period       = 100;
    localparam int reset_cycles     = 3;
    localparam int cycles_per_instr = 40;
    localparam int mem_depth        = 256;
    localparam int mem_aw           = $clog2(mem_depth);
    localparam logic [reg_idx_w-1:0] r0 = 2'd0;
    localparam logic [reg_idx_w-1:0] r1 = 2'd1;
    localparam logic [reg_idx_w-1:0] r2 = 2'd2;
    localparam logic [reg_idx_w-1:0] r3 = 2'd3;

    logic                 clk;
    logic                 reset_n;
    logic [word_size-1:0] i_addr;
    logic [word_size-1:0] i_data;
    logic [word_size-1:0] d_addr;
    logic [word_size-1:0] d_rdata;
    logic [word_size-1:0] d_wdata;
    logic                 d_write;
    logic [word_size-1:0] out_port;
    logic                 out_valid;
    logic                 halted;

    integer               seed;
    int                   errors;
    int                   checks;
    bit                   prog_loaded;
    logic [word_size-1:0] prog [$];
    logic [word_size-1:0] ref_mem [mem_depth];
    logic [word_size-1:0] exp_out [$];
    logic [word_size-1:0] exp_addr [$];
    logic [word_size-1:0] exp_wdata [$];

    tsc_core u_tsc_core (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_addr    (i_addr),
        .i_data    (i_data),
        .d_addr    (d_addr),
        .d_rdata   (d_rdata),
        .d_wdata   (d_wdata),
        .d_write   (d_write),
        .out_port  (out_port),
        .out_valid (out_valid),
        .halted    (halted)
    );

    tsc_mem_model #(.depth(mem_depth)) u_mem (
        .clk     (clk),
        .reset_n (reset_n),
        .i_addr  (i_addr),
        .i_data  (i_data),
        .d_addr  (d_addr),
        .d_rdata (d_rdata),
        .d_wdata (d_wdata),
        .d_write (d_write)
    );

    function automatic logic [word_size-1:0] encode_r(logic [reg_idx_w-1:0] rs,
        logic [reg_idx_w-1:0] rt, logic [reg_idx_w-1:0] rd, logic [5:0] fn);
        return {op_rtype, rs, rt, rd, fn};
    endfunction

    function automatic logic [word_size-1:0] encode_i(logic [3:0] op,
        logic [reg_idx_w-1:0] rs, logic [reg_idx_w-1:0] rt, logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Back-to-back and one-apart dependencies, loads of stored and random words
    task automatic build_program();
        prog.push_back(encode_i(op_adi, r0, r1, 8'd5));
        prog.push_back(encode_i(op_adi, r0, r2, 8'hfd));
        prog.push_back(encode_r(r1, r2, r3, fn_add));
        prog.push_back(encode_r(r3, r0, r0, fn_wwd));
        prog.push_back(encode_r(r1, r2, r3, fn_sub));
        prog.push_back(encode_r(r3, r0, r0, fn_wwd));
        prog.push_back(encode_r(r1, r2, r3, fn_orr));
        prog.push_back(encode_r(r1, r3, r0, fn_and));
        prog.push_back(encode_r(r0, r0, r0, fn_wwd));
        prog.push_back(encode_i(op_swd, r1, r3, 8'd16));
        prog.push_back(encode_i(op_lwd, r1, r0, 8'd16));
        prog.push_back(encode_r(r0, r0, r0, fn_wwd));
        prog.push_back(encode_i(op_lwd, r1, r2, 8'd40));
        prog.push_back(encode_i(op_adi, r2, r2, 8'd1));
        prog.push_back(encode_r(r2, r0, r0, fn_wwd));
        prog.push_back(encode_i(op_adi, r1, r1, 8'd1));
        prog.push_back(encode_i(op_swd, r1, r2, 8'd16));
        prog.push_back(encode_i(op_adi, r0, r3, 8'd7));
        prog.push_back(encode_r(r1, r0, r0, fn_wwd));
        prog.push_back(encode_r(r3, r0, r0, fn_wwd));
        prog.push_back(encode_i(op_lwd, r1, r3, 8'd16));
        prog.push_back(encode_r(r3, r0, r0, fn_wwd));
        prog.push_back(encode_r(r0, r0, r0, fn_hlt));
    endtask

    // Words past the program are stores, so anything fetched after HLT shows up
    task automatic load_memories();
        logic [31:0] rnd;
        for (int i = 0; i < mem_depth; i++) begin
            rnd = $random(seed);
            ref_mem[i] = rnd[word_size-1:0];
            u_mem.ram_init[i] = rnd[word_size-1:0];
            u_mem.rom[i] = (i < prog.size()) ? prog[i] :
                encode_i(op_swd, r0, r1, i[mem_aw-1:0]);
        end
    endtask

    // Executes the program one instruction at a time, in order
    task automatic run_reference();
        logic [word_size-1:0] regs [reg_count];
        logic [word_size-1:0] instr;
        logic [word_size-1:0] a;
        logic [word_size-1:0] b;
        logic [word_size-1:0] sum_imm;
        bit                   done;
        int                   pc;
        for (int i = 0; i < reg_count; i++) begin
            regs[i] = '0;
        end
        done = 1'b0;
        pc = 0;
        while (!done && pc < prog.size()) begin
            instr = prog[pc];
            a = regs[instr[11:10]];
            b = regs[instr[9:8]];
            sum_imm = a + {{(word_size-8){instr[7]}}, instr[7:0]};
            case (instr[15:12])
                op_rtype: begin
                    case (instr[5:0])
                        fn_add: regs[instr[7:6]] = a + b;
                        fn_sub: regs[instr[7:6]] = a - b;
                        fn_and: regs[instr[7:6]] = a & b;
                        fn_orr: regs[instr[7:6]] = a | b;
                        fn_wwd: exp_out.push_back(a);
                        fn_hlt: done = 1'b1;
                        default: ;
                    endcase
                end
                op_adi: regs[instr[9:8]] = sum_imm;
                op_lwd: regs[instr[9:8]] = ref_mem[sum_imm[mem_aw-1:0]];
                op_swd: begin
                    ref_mem[sum_imm[mem_aw-1:0]] = b;
                    exp_addr.push_back(sum_imm);
                    exp_wdata.push_back(b);
                end
                default: ;
            endcase
            pc++;
        end
    endtask

    task automatic compare_output();
        logic [word_size-1:0] expected;
        checks++;
        assert (exp_out.size() > 0) else begin
            errors++;
            $display("Output pulse with no WWD value left to expect");
        end
        if (exp_out.size() > 0) begin
            expected = exp_out.pop_front();
            assert (out_port === expected) else begin
                errors++;
                $display("FAILED out_port expected 0x%04h got 0x%04h", expected, out_port);
            end
        end
    endtask

    task automatic verify_store();
        logic [word_size-1:0] addr;
        logic [word_size-1:0] data;
        checks++;
        assert (exp_addr.size() > 0) else begin
            errors++;
            $display("Data write with no store left to expect");
        end
        if (exp_addr.size() > 0) begin
            addr = exp_addr.pop_front();
            data = exp_wdata.pop_front();
            assert (d_addr === addr) else begin
                errors++;
                $display("FAILED d_addr expected 0x%04h got 0x%04h", addr, d_addr);
            end
            assert (d_wdata === data) else begin
                errors++;
                $display("FAILED d_wdata expected 0x%04h got 0x%04h", data, d_wdata);
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!reset_n) begin
            if (out_valid) begin
                compare_output();
            end
            if (d_write) begin
                verify_store();
            end
        end
    end

    assert property (@(posedge clk) reset_n |=> !out_valid && !d_write && !halted)
        else begin
            errors++;
            $display("Output strobe or halted high during or right after reset");
        end

    // Fetch restarts from address zero
    assert property (@(posedge clk) reset_n |=> i_addr == '0)
        else begin
            errors++;
            $display("FAILED i_addr expected 0x0000 got 0x%04h", $sampled(i_addr));
        end

    assert property (@(posedge clk) disable iff (reset_n) halted |=> halted)
        else begin
            errors++;
            $display("Halted dropped after it was set");
        end

    assert property (@(posedge clk) disable iff (reset_n) halted |-> !out_valid && !d_write)
        else begin
            errors++;
            $display("Output or store pulse after the core halted");
        end

    initial begin
        wait (prog_loaded);
        #(prog.size() * cycles_per_instr * clk_period);
        $display("Timeout, core did not halt within %0d cycles", prog.size() * cycles_per_instr);
        $display("Checks: %0d  errors: %0d", checks, errors);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        reset_n = 1'b1;
        seed = 32'h1b9e6e70;
        errors = 0;
        checks = 0;
        build_program();
        load_memories();
        run_reference();
        prog_loaded = 1'b1;
        repeat (reset_cycles) @(negedge clk);
        reset_n = 1'b0;
        while (!halted) begin
            @(negedge clk);
        end
        // A few more cycles to catch stray pulses past the halt
        repeat (8) @(negedge clk);
        assert (exp_out.size() == 0) else begin
            errors++;
            $display("%0d expected WWD values never appeared", exp_out.size());
        end
        assert (exp_addr.size() == 0) else begin
            errors++;
            $display("%0d expected stores never appeared", exp_addr.size());
        end
        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tsc_core.f ====
src/tsc_pkg.sv
src/pipe_reg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/tsc_core.sv
dv/tsc_mem_model.sv
dv/tsc_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tsc_core_tb
FILELIST  ?= tsc_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
